// ==== vlog.f ====
+incdir+.
mem_pkg.sv
boot_loader.sv
sram_port.sv
sram_model.sv
mem_subsys.sv
tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mem_pkg.sv
      - boot_loader.sv
      - sram_port.sv
      - sram_model.sv
      - mem_subsys.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_subsys.sv

// ==== tb_mem_subsys.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "mem_macros.svh"

module tb_mem_subsys;

	typedef enum {STEP_LOAD, STEP_DONE, STEP_READ, STEP_WRITE, STEP_IDLE} step_e;

	localparam int MAX_ROWS = 64;

	logic                        tb_CLK;
	logic                        rst;
	logic                        load_valid;
	mem_pkg::load_target_e       load_target;
	logic [`MEM_DATA_W-1:0]      load_data;
	logic                        load_done;
	logic                        run;
	logic                        i_req;
	mem_pkg::mem_op_e            i_op;
	logic [`MEM_ADDR_W-1:0]      i_addr;
	logic [`MEM_DATA_W-1:0]      i_wdata;
	logic                        i_rvalid;
	logic [`MEM_DATA_W-1:0]      i_rdata;
	logic                        d_req;
	mem_pkg::mem_op_e            d_op;
	logic [`MEM_ADDR_W-1:0]      d_addr;
	logic [`MEM_DATA_W-1:0]      d_wdata;
	logic                        d_rvalid;
	logic [`MEM_DATA_W-1:0]      d_rdata;

	// Stimulus table, one entry per cycle
	step_e                       row_kind [MAX_ROWS];
	mem_pkg::load_target_e       row_chan [MAX_ROWS];
	logic [`MEM_ADDR_W-1:0]      row_addr [MAX_ROWS];
	logic [`MEM_DATA_W-1:0]      row_data [MAX_ROWS];
	logic [`MEM_DATA_W-1:0]      row_exp  [MAX_ROWS];
	logic                        row_run  [MAX_ROWS];
	logic                        row_acc  [MAX_ROWS];
	int                          n_rows;
	int                          done_row;

	// Expected memory contents
	logic [`MEM_DATA_W-1:0]      i_shadow [`MEM_DEPTH];
	logic [`MEM_DATA_W-1:0]      d_shadow [`MEM_DEPTH];
	int                          i_cnt;
	int                          d_cnt;

	int                          errors;
	int                          cycle_cnt;
	int                          cycle_limit = 1000;

	mem_subsys DUT (
		.tb_CLK      (tb_CLK),
		.rst         (rst),
		.load_valid  (load_valid),
		.load_target (load_target),
		.load_data   (load_data),
		.load_done   (load_done),
		.run         (run),
		.i_req       (i_req),
		.i_op        (i_op),
		.i_addr      (i_addr),
		.i_wdata     (i_wdata),
		.i_rvalid    (i_rvalid),
		.i_rdata     (i_rdata),
		.d_req       (d_req),
		.d_op        (d_op),
		.d_addr      (d_addr),
		.d_wdata     (d_wdata),
		.d_rvalid    (d_rvalid),
		.d_rdata     (d_rdata)
	);

	initial tb_CLK = 1'b0;
	always #10 tb_CLK = ~tb_CLK;

	// Run limit
	always @(posedge tb_CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: the stimulus loop did not end within %0d cycles", cycle_limit);
			$display("Some tests failed");
			$finish;
		end
	end

	// ----------------------------------------
	// Compare tasks
	// ----------------------------------------
	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("Error: time %0t, %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input logic [`MEM_DATA_W-1:0] exp,
		input logic [`MEM_DATA_W-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("Error: time %0t, %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	// One rvalid pulse per accepted request, none for a dropped one
	task automatic check_op_resp(input string name, input mem_pkg::mem_op_e op,
		input logic exp, input logic act);
		string op_txt;
		op_txt = (op == mem_pkg::MEM_WRITE) ? "write" : "read";
		if (act !== exp) begin
			errors++;
			$display("Error: time %0t, %s after core %s expected %b, got %b",
				$time, name, op_txt, exp, act);
		end
	endtask

	function automatic mem_pkg::mem_op_e op_of(input int r);
		return (row_kind[r] == STEP_WRITE) ? mem_pkg::MEM_WRITE : mem_pkg::MEM_READ;
	endfunction

	// ----------------------------------------
	// Table construction
	// ----------------------------------------
	task automatic add_row(input step_e kind, input mem_pkg::load_target_e chan,
		input int addr, input logic [`MEM_DATA_W-1:0] data);
		logic accepted;
		// Core request needs run high before the edge that samples it
		accepted = (done_row >= 0) && (n_rows > done_row + 1);
		row_kind[n_rows] = kind;
		row_chan[n_rows] = chan;
		row_addr[n_rows] = addr[`MEM_ADDR_W-1:0];
		row_data[n_rows] = data;
		row_exp[n_rows]  = '0;
		row_run[n_rows]  = (done_row >= 0) && (n_rows > done_row);
		row_acc[n_rows]  = accepted && (kind == STEP_READ || kind == STEP_WRITE);
		case (kind)
			STEP_LOAD: begin
				// Words after load_done are ignored
				if (done_row < 0 && chan == mem_pkg::TARGET_IMEM) begin
					i_shadow[i_cnt] = data;
					i_cnt++;
				end else if (done_row < 0) begin
					d_shadow[d_cnt] = data;
					d_cnt++;
				end
			end
			STEP_DONE: begin
				done_row = n_rows;
			end
			STEP_WRITE: begin
				if (accepted && chan == mem_pkg::TARGET_IMEM) begin
					i_shadow[addr] = data;
				end else if (accepted) begin
					d_shadow[addr] = data;
				end
			end
			STEP_READ: begin
				if (accepted) begin
					row_exp[n_rows] = (chan == mem_pkg::TARGET_IMEM) ? i_shadow[addr] : d_shadow[addr];
				end
			end
			default: begin
			end
		endcase
		n_rows++;
	endtask

	task automatic build_table();
		// Dropped, run still low
		add_row(STEP_READ, mem_pkg::TARGET_DMEM, 0, '0);
		add_row(STEP_READ, mem_pkg::TARGET_IMEM, 0, '0);
		// Interleaved image
		add_row(STEP_LOAD, mem_pkg::TARGET_IMEM, 0, $urandom);
		add_row(STEP_LOAD, mem_pkg::TARGET_DMEM, 0, $urandom);
		add_row(STEP_LOAD, mem_pkg::TARGET_IMEM, 0, $urandom);
		add_row(STEP_LOAD, mem_pkg::TARGET_DMEM, 0, $urandom);
		add_row(STEP_LOAD, mem_pkg::TARGET_DMEM, 0, $urandom);
		add_row(STEP_LOAD, mem_pkg::TARGET_IMEM, 0, $urandom);
		add_row(STEP_LOAD, mem_pkg::TARGET_IMEM, 0, $urandom);
		add_row(STEP_LOAD, mem_pkg::TARGET_DMEM, 0, $urandom);
		add_row(STEP_DONE, mem_pkg::TARGET_IMEM, 0, '0);
		add_row(STEP_IDLE, mem_pkg::TARGET_IMEM, 0, '0);
		// Back-to-back readback
		for (int a = 0; a < 4; a++) begin
			add_row(STEP_READ, mem_pkg::TARGET_IMEM, a, '0);
		end
		for (int a = 0; a < 4; a++) begin
			add_row(STEP_READ, mem_pkg::TARGET_DMEM, a, '0);
		end
		// Data write, then the word and its neighbors
		add_row(STEP_WRITE, mem_pkg::TARGET_DMEM, 1, $urandom);
		add_row(STEP_READ, mem_pkg::TARGET_DMEM, 1, '0);
		add_row(STEP_READ, mem_pkg::TARGET_DMEM, 0, '0);
		add_row(STEP_READ, mem_pkg::TARGET_DMEM, 2, '0);
		// Mark the next counter addresses, then strobe late words
		add_row(STEP_WRITE, mem_pkg::TARGET_IMEM, 4, $urandom);
		add_row(STEP_WRITE, mem_pkg::TARGET_DMEM, 4, $urandom);
		add_row(STEP_LOAD, mem_pkg::TARGET_IMEM, 0, $urandom);
		add_row(STEP_LOAD, mem_pkg::TARGET_DMEM, 0, $urandom);
		add_row(STEP_IDLE, mem_pkg::TARGET_IMEM, 0, '0);
		add_row(STEP_READ, mem_pkg::TARGET_IMEM, 4, '0);
		add_row(STEP_READ, mem_pkg::TARGET_DMEM, 4, '0);
		add_row(STEP_READ, mem_pkg::TARGET_IMEM, 3, '0);
		add_row(STEP_READ, mem_pkg::TARGET_DMEM, 1, '0);
	endtask

	// ----------------------------------------
	// Drive and check
	// ----------------------------------------
	task automatic drive_idle();
		load_valid  = 1'b0;
		load_target = mem_pkg::TARGET_IMEM;
		load_data   = '0;
		load_done   = 1'b0;
		i_req       = 1'b0;
		i_op        = mem_pkg::MEM_READ;
		i_addr      = '0;
		i_wdata     = '0;
		d_req       = 1'b0;
		d_op        = mem_pkg::MEM_READ;
		d_addr      = '0;
		d_wdata     = '0;
	endtask

	task automatic drive_row(input int r);
		drive_idle();
		case (row_kind[r])
			STEP_LOAD: begin
				load_valid  = 1'b1;
				load_target = row_chan[r];
				load_data   = row_data[r];
			end
			STEP_DONE: begin
				load_done = 1'b1;
			end
			STEP_READ, STEP_WRITE: begin
				if (row_chan[r] == mem_pkg::TARGET_IMEM) begin
					i_req   = 1'b1;
					i_op    = op_of(r);
					i_addr  = row_addr[r];
					i_wdata = row_data[r];
				end else begin
					d_req   = 1'b1;
					d_op    = op_of(r);
					d_addr  = row_addr[r];
					d_wdata = row_data[r];
				end
			end
			default: begin
			end
		endcase
	endtask

	task automatic check_chan(input int r, input mem_pkg::load_target_e ch, input logic rv,
		input logic [`MEM_DATA_W-1:0] rd, input string rv_name, input string rd_name);
		logic is_req;
		is_req = (row_kind[r] == STEP_READ || row_kind[r] == STEP_WRITE) && (row_chan[r] == ch);
		if (is_req) begin
			check_op_resp(rv_name, op_of(r), row_acc[r], rv);
			// Write data on rdata is undefined
			if (row_kind[r] == STEP_READ && row_acc[r]) begin
				check_word(rd_name, row_exp[r], rd);
			end
		end else begin
			check_bit(rv_name, 1'b0, rv);
		end
	endtask

	task automatic check_row(input int r);
		check_bit("run", row_run[r], run);
		check_chan(r, mem_pkg::TARGET_IMEM, i_rvalid, i_rdata, "i_rvalid", "i_rdata");
		check_chan(r, mem_pkg::TARGET_DMEM, d_rvalid, d_rdata, "d_rvalid", "d_rdata");
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		errors    = 0;
		cycle_cnt = 0;
		n_rows    = 0;
		done_row  = -1;
		i_cnt     = 0;
		d_cnt     = 0;
		rst       = 1'b1;
		drive_idle();
		void'($urandom(42814));
		build_table();
		cycle_limit = n_rows * 4 + 20;

		repeat (2) @(posedge tb_CLK);
		#2;
		rst = 1'b0;
		@(negedge tb_CLK);
		check_bit("run", 1'b0, run);
		check_bit("i_rvalid", 1'b0, i_rvalid);
		check_bit("d_rvalid", 1'b0, d_rvalid);

		// Row r is sampled one edge after it is driven
		for (int r = 0; r <= n_rows; r++) begin
			@(posedge tb_CLK);
			#2;
			if (r < n_rows) begin
				drive_row(r);
			end else begin
				drive_idle();
			end
			if (r > 0) begin
				@(negedge tb_CLK);
				check_row(r - 1);
			end
		end

		$display("Run finished after %0d rows with %0d errors", n_rows, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== mem_subsys.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "mem_macros.svh"

module mem_subsys (
	input  wire                         tb_CLK,
	input  wire                         rst,

	// Image stream
	input  wire                         load_valid,
	input  mem_pkg::load_target_e       load_target,
	input  wire  [`MEM_DATA_W-1:0]      load_data,
	input  wire                         load_done,
	output logic                        run,

	// Instruction channel
	input  wire                         i_req,
	input  mem_pkg::mem_op_e            i_op,
	input  wire  [`MEM_ADDR_W-1:0]      i_addr,
	input  wire  [`MEM_DATA_W-1:0]      i_wdata,
	output logic                        i_rvalid,
	output logic [`MEM_DATA_W-1:0]      i_rdata,

	// Data channel
	input  wire                         d_req,
	input  mem_pkg::mem_op_e            d_op,
	input  wire  [`MEM_ADDR_W-1:0]      d_addr,
	input  wire  [`MEM_DATA_W-1:0]      d_wdata,
	output logic                        d_rvalid,
	output logic [`MEM_DATA_W-1:0]      d_rdata
);

	// Loader requests
	logic                       i_ld_we;
	logic [`MEM_ADDR_W-1:0]     i_ld_addr;
	logic [`MEM_DATA_W-1:0]     i_ld_data;
	logic                       d_ld_we;
	logic [`MEM_ADDR_W-1:0]     d_ld_addr;
	logic [`MEM_DATA_W-1:0]     d_ld_data;

	// Instruction SRAM pins
	logic                       i_csb;
	logic                       i_web;
	logic [`MEM_ADDR_W-1:0]     i_sram_addr;
	logic [`MEM_DATA_W-1:0]     i_sram_din;
	logic [`MEM_DATA_W-1:0]     i_sram_dout;

	// Data SRAM pins
	logic                       d_csb;
	logic                       d_web;
	logic [`MEM_ADDR_W-1:0]     d_sram_addr;
	logic [`MEM_DATA_W-1:0]     d_sram_din;
	logic [`MEM_DATA_W-1:0]     d_sram_dout;

	// ----------------------------------------
	// Boot loader
	// ----------------------------------------
	boot_loader u_boot_loader (
		.tb_CLK      (tb_CLK),
		.rst         (rst),
		.load_valid  (load_valid),
		.load_target (load_target),
		.load_data   (load_data),
		.load_done   (load_done),
		.i_ld_we     (i_ld_we),
		.i_ld_addr   (i_ld_addr),
		.i_ld_data   (i_ld_data),
		.d_ld_we     (d_ld_we),
		.d_ld_addr   (d_ld_addr),
		.d_ld_data   (d_ld_data),
		.run         (run)
	);

	// ----------------------------------------
	// Instruction channel
	// ----------------------------------------
	sram_port u_imem_port (
		.tb_CLK    (tb_CLK),
		.rst       (rst),
		.run       (run),
		.ld_we     (i_ld_we),
		.ld_addr   (i_ld_addr),
		.ld_data   (i_ld_data),
		.req       (i_req),
		.op        (i_op),
		.addr      (i_addr),
		.wdata     (i_wdata),
		.rvalid    (i_rvalid),
		.rdata     (i_rdata),
		.csb       (i_csb),
		.web       (i_web),
		.sram_addr (i_sram_addr),
		.sram_din  (i_sram_din),
		.sram_dout (i_sram_dout)
	);

	sram_model u_imem (
		.tb_CLK (tb_CLK),
		.csb    (i_csb),
		.web    (i_web),
		.addr   (i_sram_addr),
		.din    (i_sram_din),
		.dout   (i_sram_dout)
	);

	// ----------------------------------------
	// Data channel
	// ----------------------------------------
	sram_port u_dmem_port (
		.tb_CLK    (tb_CLK),
		.rst       (rst),
		.run       (run),
		.ld_we     (d_ld_we),
		.ld_addr   (d_ld_addr),
		.ld_data   (d_ld_data),
		.req       (d_req),
		.op        (d_op),
		.addr      (d_addr),
		.wdata     (d_wdata),
		.rvalid    (d_rvalid),
		.rdata     (d_rdata),
		.csb       (d_csb),
		.web       (d_web),
		.sram_addr (d_sram_addr),
		.sram_din  (d_sram_din),
		.sram_dout (d_sram_dout)
	);

	sram_model u_dmem (
		.tb_CLK (tb_CLK),
		.csb    (d_csb),
		.web    (d_web),
		.addr   (d_sram_addr),
		.din    (d_sram_din),
		.dout   (d_sram_dout)
	);

endmodule

`default_nettype wire

// ==== sram_model.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "mem_macros.svh"

module sram_model (
	input  wire                         tb_CLK,
	input  wire                         csb,
	input  wire                         web,
	input  wire  [`MEM_ADDR_W-1:0]      addr,
	input  wire  [`MEM_DATA_W-1:0]      din,
	output logic [`MEM_DATA_W-1:0]      dout
);

	// Storage array
	logic [`MEM_DATA_W-1:0] mem [`MEM_DEPTH];

	// ----------------------------------------
	// Single port, one access per edge
	// ----------------------------------------
	always_ff @(posedge tb_CLK) begin
		if (!csb) begin
			if (!web) begin
				mem[addr] <= din;
			end else begin
				// dout keeps its value on writes and idle cycles
				dout <= mem[addr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== sram_port.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "mem_macros.svh"

module sram_port (
	input  wire                         tb_CLK,
	input  wire                         rst,
	input  wire                         run,

	// Boot loader write
	input  wire                         ld_we,
	input  wire  [`MEM_ADDR_W-1:0]      ld_addr,
	input  wire  [`MEM_DATA_W-1:0]      ld_data,

	// Core request and response
	input  wire                         req,
	input  mem_pkg::mem_op_e            op,
	input  wire  [`MEM_ADDR_W-1:0]      addr,
	input  wire  [`MEM_DATA_W-1:0]      wdata,
	output logic                        rvalid,
	output logic [`MEM_DATA_W-1:0]      rdata,

	// SRAM side, strobes active low
	output logic                        csb,
	output logic                        web,
	output logic [`MEM_ADDR_W-1:0]      sram_addr,
	output logic [`MEM_DATA_W-1:0]      sram_din,
	input  wire  [`MEM_DATA_W-1:0]      sram_dout
);

	// ----------------------------------------
	// Request stage
	// ----------------------------------------
	always_comb begin
		if (run) begin
			csb       = ~req;
			web       = (op != mem_pkg::MEM_WRITE);
			sram_addr = addr;
			sram_din  = wdata;
		end else begin
			// Loader owns the SRAM, core requests fall on the floor
			csb       = ~ld_we;
			web       = 1'b0;
			sram_addr = ld_addr;
			sram_din  = ld_data;
		end
	end

	// ----------------------------------------
	// Response stage
	// ----------------------------------------
	always_ff @(posedge tb_CLK) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else begin
			rvalid <= run && req;
		end
	end

	// SRAM output is already registered
	assign rdata = sram_dout;

endmodule

`default_nettype wire

// ==== boot_loader.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "mem_macros.svh"

module boot_loader (
	input  wire                         tb_CLK,
	input  wire                         rst,

	// Image stream
	input  wire                         load_valid,
	input  mem_pkg::load_target_e       load_target,
	input  wire  [`MEM_DATA_W-1:0]      load_data,
	input  wire                         load_done,

	// Instruction memory write request
	output logic                        i_ld_we,
	output logic [`MEM_ADDR_W-1:0]      i_ld_addr,
	output logic [`MEM_DATA_W-1:0]      i_ld_data,

	// Data memory write request
	output logic                        d_ld_we,
	output logic [`MEM_ADDR_W-1:0]      d_ld_addr,
	output logic [`MEM_DATA_W-1:0]      d_ld_data,

	output logic                        run
);

	mem_pkg::boot_state_e state;

	// Per-target request registers, indexed by load_target
	logic [1:0]                   ld_we;
	logic [`MEM_ADDR_W-1:0]       ld_addr [2];
	logic [`MEM_DATA_W-1:0]       ld_data [2];
	logic [`MEM_ADDR_W-1:0]       cnt     [2];

	logic accept;

	// Words are only taken while still loading
	assign accept = load_valid && (state == mem_pkg::BOOT_LOAD);

	// ----------------------------------------
	// Control state
	// ----------------------------------------
	always_ff @(posedge tb_CLK) begin
		if (rst) begin
			state  <= mem_pkg::BOOT_LOAD;
			run    <= 1'b0;
			ld_we  <= 2'b00;
			cnt[0] <= '0;
			cnt[1] <= '0;
		end else begin
			// One cycle behind the state, so the last word lands before
			// core traffic takes the port
			run   <= (state == mem_pkg::BOOT_RUN);
			ld_we <= 2'b00;
			if (accept) begin
				ld_we[load_target] <= 1'b1;
				cnt[load_target]   <= cnt[load_target] + 1'b1;
			end
			if (state == mem_pkg::BOOT_LOAD && load_done) begin
				state <= mem_pkg::BOOT_RUN;
			end
		end
	end

	// Address and data of the pending write
	always_ff @(posedge tb_CLK) begin
		if (accept) begin
			ld_addr[load_target] <= cnt[load_target];
			ld_data[load_target] <= load_data;
		end
	end

	// ----------------------------------------
	// Split onto the two channels
	// ----------------------------------------
	assign i_ld_we   = ld_we[mem_pkg::TARGET_IMEM];
	assign i_ld_addr = ld_addr[mem_pkg::TARGET_IMEM];
	assign i_ld_data = ld_data[mem_pkg::TARGET_IMEM];

	assign d_ld_we   = ld_we[mem_pkg::TARGET_DMEM];
	assign d_ld_addr = ld_addr[mem_pkg::TARGET_DMEM];
	assign d_ld_data = ld_data[mem_pkg::TARGET_DMEM];

endmodule

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// ----------------------------------------
	// Core side operation
	// ----------------------------------------
	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_op_e;

	// Destination memory of an image word
	typedef enum logic {
		TARGET_IMEM = 1'b0,
		TARGET_DMEM = 1'b1
	} load_target_e;

	// Boot phase
	typedef enum logic {
		BOOT_LOAD = 1'b0,
		BOOT_RUN  = 1'b1
	} boot_state_e;

endpackage

`default_nettype wire

// ==== mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// ----------------------------------------
// Memory geometry
// ----------------------------------------

// Word address into one SRAM
`define MEM_ADDR_W 10

// One machine word
`define MEM_DATA_W 32

// Words per SRAM, 2**MEM_ADDR_W
`define MEM_DEPTH 1024

`endif
